// ==== src/udp_pkg.sv ====
package udp_pkg;

  // one byte of a datagram stream.
  typedef struct packed {
    logic [7:0] data;
    logic       sof;
    logic       eof;
  } udp_beat_t;

  // sampled together with the sof beat of a transmit datagram.
  typedef struct packed {
    logic [15:0] dst_port;
    logic [15:0] payload_len;
  } udp_tx_meta_t;

  // presented with every received payload beat.
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] payload_len;
  } udp_rx_meta_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_PAYLOAD
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_HDR,
    RX_PAYLOAD,
    RX_DROP
  } rx_state_e;

  typedef enum logic {
    ANN_SEND,
    ANN_DONE
  } ann_state_e;

  localparam logic [15:0] UDP_HDR_LEN   = 16'd8;
  localparam logic [15:0] LOCAL_PORT    = 16'd5000;
  localparam logic [15:0] ANNOUNCE_PORT = 16'd5001;
  localparam logic [15:0] ANNOUNCE_LEN  = 16'd4;

  localparam logic [8*ANNOUNCE_LEN-1:0] ANNOUNCE_PAYLOAD = "UDPU";

  // credit limit of both transmit links, also the user FIFO depth.
  localparam int TX_CREDITS = 4;

  localparam int CREDIT_W  = $clog2(TX_CREDITS + 1);
  localparam int FIFO_AW   = $clog2(TX_CREDITS);
  localparam int HDR_CNT_W = $clog2(UDP_HDR_LEN);
  localparam int ANN_CNT_W = $clog2(ANNOUNCE_LEN);

  localparam logic [CREDIT_W-1:0]  CREDIT_MAX = CREDIT_W'(TX_CREDITS);
  localparam logic [HDR_CNT_W-1:0] HDR_LAST   = HDR_CNT_W'(UDP_HDR_LEN - 16'd1);
  localparam logic [ANN_CNT_W-1:0] ANN_LAST   = ANN_CNT_W'(ANNOUNCE_LEN - 16'd1);

endpackage : udp_pkg

// ==== src/udp_announce.sv ====
module udp_announce (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic                  ann_valid,
  output udp_pkg::udp_beat_t    ann_beat,
  output udp_pkg::udp_tx_meta_t ann_meta,
  input  logic                  ann_ready,
  output logic                  announce_done
);

  udp_pkg::ann_state_e            state;
  logic [udp_pkg::ANN_CNT_W-1:0]  idx;
  logic                           last;

  assign last = (idx == udp_pkg::ANN_LAST);

  // the announcement is sent once after reset, then the transmitter is released.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= udp_pkg::ANN_SEND;
      idx       <= '0;
      ann_valid <= 1'b0;
    end else begin
      case (state)
        udp_pkg::ANN_SEND: begin
          ann_valid <= 1'b1;
          if (ann_valid && ann_ready) begin
            idx <= idx + 1'b1;
            if (last) begin
              state     <= udp_pkg::ANN_DONE;
              ann_valid <= 1'b0;
            end
          end
        end
        default: begin
          ann_valid <= 1'b0;
        end
      endcase
    end
  end

  assign announce_done = (state == udp_pkg::ANN_DONE);

  // payload bytes go out first character first.
  always_comb begin
    ann_beat.data = udp_pkg::ANNOUNCE_PAYLOAD[8*(udp_pkg::ANNOUNCE_LEN-16'd1-16'(idx)) +: 8];
    ann_beat.sof  = (idx == '0);
    ann_beat.eof  = last;
  end

  assign ann_meta = '{dst_port:    udp_pkg::ANNOUNCE_PORT,
                      payload_len: udp_pkg::ANNOUNCE_LEN};

endmodule : udp_announce

// ==== src/udp_tx_select.sv ====
module udp_tx_select (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  user_tx_valid,
  input  udp_pkg::udp_beat_t    user_tx_beat,
  input  udp_pkg::udp_tx_meta_t user_tx_meta,
  output logic                  user_tx_credit,
  input  logic                  ann_valid,
  input  udp_pkg::udp_beat_t    ann_beat,
  input  udp_pkg::udp_tx_meta_t ann_meta,
  output logic                  ann_ready,
  input  logic                  announce_done,
  output logic                  sel_valid,
  output udp_pkg::udp_beat_t    sel_beat,
  output udp_pkg::udp_tx_meta_t sel_meta,
  input  logic                  sel_ready
);

  udp_pkg::udp_beat_t    beat_mem [udp_pkg::TX_CREDITS];
  udp_pkg::udp_tx_meta_t meta_mem [udp_pkg::TX_CREDITS];

  logic [udp_pkg::FIFO_AW-1:0]  wr_ptr;
  logic [udp_pkg::FIFO_AW-1:0]  rd_ptr;
  logic [udp_pkg::CREDIT_W-1:0] count;
  logic                         fifo_empty;
  logic                         fifo_full;
  logic                         push;
  logic                         pop;

  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == udp_pkg::CREDIT_MAX);

  // the user holds a credit per beat, so a full FIFO only guards a misbehaving source.
  assign push = user_tx_valid && !fifo_full;
  assign pop  = announce_done && !fifo_empty && sel_ready;

  // meta is stored with every entry and only the sof entry is used downstream.
  always_ff @(posedge clk) begin
    if (push) begin
      beat_mem[wr_ptr] <= user_tx_beat;
      meta_mem[wr_ptr] <= user_tx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      user_tx_credit <= 1'b0;
    end else begin
      user_tx_credit <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // announce_done rises only after the announcement's eof has transferred,
  // so the hand-over always falls between datagrams.
  always_comb begin
    if (announce_done) begin
      sel_valid = !fifo_empty;
      sel_beat  = beat_mem[rd_ptr];
      sel_meta  = meta_mem[rd_ptr];
    end else begin
      sel_valid = ann_valid;
      sel_beat  = ann_beat;
      sel_meta  = ann_meta;
    end
  end

  assign ann_ready = sel_ready && !announce_done;

endmodule : udp_tx_select

// ==== src/udp_tx_framer.sv ====
module udp_tx_framer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sel_valid,
  input  udp_pkg::udp_beat_t    sel_beat,
  input  udp_pkg::udp_tx_meta_t sel_meta,
  output logic                  sel_ready,
  output logic                  ipv4_tx_valid,
  output udp_pkg::udp_beat_t    ipv4_tx_beat,
  input  logic                  ipv4_tx_credit
);

  udp_pkg::tx_state_e                    state;
  logic [udp_pkg::CREDIT_W-1:0]          credits;
  logic [udp_pkg::HDR_CNT_W-1:0]         hdr_idx;
  udp_pkg::udp_tx_meta_t                 meta_q;
  logic [8*udp_pkg::UDP_HDR_LEN-1:0]     hdr;
  udp_pkg::udp_beat_t                    next_beat;
  logic                                  can_send;
  logic                                  send;

  assign can_send = (credits != '0);

  // big-endian header, checksum left at zero.
  assign hdr = {udp_pkg::LOCAL_PORT,
                meta_q.dst_port,
                meta_q.payload_len + udp_pkg::UDP_HDR_LEN,
                16'h0000};

  // in idle the sof beat is only inspected.
  // It is taken as the first payload byte once the header is out.
  always_comb begin
    case (state)
      udp_pkg::TX_IDLE:    sel_ready = sel_valid && !sel_beat.sof;
      udp_pkg::TX_PAYLOAD: sel_ready = can_send;
      default:             sel_ready = 1'b0;
    endcase
  end

  assign send = can_send &&
                ((state == udp_pkg::TX_HDR) ||
                 (state == udp_pkg::TX_PAYLOAD && sel_valid));

  always_comb begin
    if (state == udp_pkg::TX_HDR) begin
      next_beat.data = hdr[8*(udp_pkg::UDP_HDR_LEN-16'd1-16'(hdr_idx)) +: 8];
      next_beat.sof  = (hdr_idx == '0);
      next_beat.eof  = 1'b0;
    end else begin
      next_beat.data = sel_beat.data;
      next_beat.sof  = 1'b0;
      next_beat.eof  = sel_beat.eof;
    end
  end

  always_ff @(posedge clk) begin
    if (state == udp_pkg::TX_IDLE && sel_valid && sel_beat.sof) begin
      meta_q <= sel_meta;
    end
    if (send) begin
      ipv4_tx_beat <= next_beat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= udp_pkg::TX_IDLE;
      hdr_idx       <= '0;
      credits       <= udp_pkg::CREDIT_MAX;
      ipv4_tx_valid <= 1'b0;
    end else begin
      ipv4_tx_valid <= send;
      case (state)
        udp_pkg::TX_IDLE: begin
          if (sel_valid && sel_beat.sof) begin
            state   <= udp_pkg::TX_HDR;
            hdr_idx <= '0;
          end
        end
        udp_pkg::TX_HDR: begin
          if (can_send) begin
            hdr_idx <= hdr_idx + 1'b1;
            if (hdr_idx == udp_pkg::HDR_LAST) begin
              state <= udp_pkg::TX_PAYLOAD;
            end
          end
        end
        default: begin
          if (send && sel_beat.eof) begin
            state <= udp_pkg::TX_IDLE;
          end
        end
      endcase
      case ({send, ipv4_tx_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule : udp_tx_framer

// ==== src/udp_rx_parser.sv ====
module udp_rx_parser (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ipv4_rx_valid,
  input  udp_pkg::udp_beat_t    ipv4_rx_beat,
  output logic                  user_rx_valid,
  output udp_pkg::udp_beat_t    user_rx_beat,
  output udp_pkg::udp_rx_meta_t user_rx_meta,
  output logic                  user_rx_err
);

  udp_pkg::rx_state_e             state;
  logic [udp_pkg::HDR_CNT_W-1:0]  hdr_cnt;
  logic [udp_pkg::HDR_CNT_W-1:0]  hdr_idx;
  logic                           in_hdr;
  logic [15:0]                    src_port_q;
  logic [15:0]                    dst_port_q;
  logic [15:0]                    len_q;
  logic [15:0]                    pay_cnt;
  logic [15:0]                    exp_len;
  logic                           first_q;

  // a sof always restarts header collection, whatever the state.
  assign hdr_idx = ipv4_rx_beat.sof ? '0 : hdr_cnt;
  assign in_hdr  = ipv4_rx_valid &&
                   (ipv4_rx_beat.sof || (state == udp_pkg::RX_HDR && hdr_cnt != '0));
  assign exp_len = len_q - udp_pkg::UDP_HDR_LEN;

  always_ff @(posedge clk) begin
    if (in_hdr) begin
      case (hdr_idx)
        3'd0:    src_port_q[15:8] <= ipv4_rx_beat.data;
        3'd1:    src_port_q[7:0]  <= ipv4_rx_beat.data;
        3'd2:    dst_port_q[15:8] <= ipv4_rx_beat.data;
        3'd3:    dst_port_q[7:0]  <= ipv4_rx_beat.data;
        3'd4:    len_q[15:8]      <= ipv4_rx_beat.data;
        3'd5:    len_q[7:0]       <= ipv4_rx_beat.data;
        default: ;
      endcase
    end
    if (ipv4_rx_valid && !in_hdr && state == udp_pkg::RX_PAYLOAD) begin
      user_rx_beat <= '{data: ipv4_rx_beat.data, sof: first_q, eof: ipv4_rx_beat.eof};
      user_rx_meta <= '{src_port: src_port_q, payload_len: exp_len};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= udp_pkg::RX_HDR;
      hdr_cnt       <= '0;
      pay_cnt       <= '0;
      first_q       <= 1'b0;
      user_rx_valid <= 1'b0;
      user_rx_err   <= 1'b0;
    end else begin
      user_rx_valid <= 1'b0;
      user_rx_err   <= 1'b0;
      if (in_hdr) begin
        if (ipv4_rx_beat.eof) begin
          // truncated header, nothing is delivered.
          state   <= udp_pkg::RX_HDR;
          hdr_cnt <= '0;
        end else if (hdr_idx == udp_pkg::HDR_LAST) begin
          hdr_cnt <= '0;
          pay_cnt <= '0;
          first_q <= 1'b1;
          state   <= (dst_port_q == udp_pkg::LOCAL_PORT) ? udp_pkg::RX_PAYLOAD
                                                         : udp_pkg::RX_DROP;
        end else begin
          state   <= udp_pkg::RX_HDR;
          hdr_cnt <= hdr_idx + 1'b1;
        end
      end else if (ipv4_rx_valid) begin
        case (state)
          udp_pkg::RX_PAYLOAD: begin
            user_rx_valid <= 1'b1;
            first_q       <= 1'b0;
            pay_cnt       <= pay_cnt + 16'd1;
            user_rx_err   <= ipv4_rx_beat.eof && ((pay_cnt + 16'd1) != exp_len);
            if (ipv4_rx_beat.eof) begin
              state <= udp_pkg::RX_HDR;
            end
          end
          udp_pkg::RX_DROP: begin
            if (ipv4_rx_beat.eof) begin
              state <= udp_pkg::RX_HDR;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule : udp_rx_parser

// ==== src/udp_top.sv ====
module udp_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  user_tx_valid,
  input  udp_pkg::udp_beat_t    user_tx_beat,
  input  udp_pkg::udp_tx_meta_t user_tx_meta,
  output logic                  user_tx_credit,
  output logic                  ipv4_tx_valid,
  output udp_pkg::udp_beat_t    ipv4_tx_beat,
  input  logic                  ipv4_tx_credit,
  input  logic                  ipv4_rx_valid,
  input  udp_pkg::udp_beat_t    ipv4_rx_beat,
  output logic                  user_rx_valid,
  output udp_pkg::udp_beat_t    user_rx_beat,
  output udp_pkg::udp_rx_meta_t user_rx_meta,
  output logic                  user_rx_err
);

  logic                  ann_valid;
  udp_pkg::udp_beat_t    ann_beat;
  udp_pkg::udp_tx_meta_t ann_meta;
  logic                  ann_ready;
  logic                  announce_done;

  logic                  sel_valid;
  udp_pkg::udp_beat_t    sel_beat;
  udp_pkg::udp_tx_meta_t sel_meta;
  logic                  sel_ready;

  // the announcement owns the transmitter until it has been sent.
  udp_announce udp_announce_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ann_valid     (ann_valid),
    .ann_beat      (ann_beat),
    .ann_meta      (ann_meta),
    .ann_ready     (ann_ready),
    .announce_done (announce_done)
  );

  udp_tx_select udp_tx_select_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .user_tx_valid  (user_tx_valid),
    .user_tx_beat   (user_tx_beat),
    .user_tx_meta   (user_tx_meta),
    .user_tx_credit (user_tx_credit),
    .ann_valid      (ann_valid),
    .ann_beat       (ann_beat),
    .ann_meta       (ann_meta),
    .ann_ready      (ann_ready),
    .announce_done  (announce_done),
    .sel_valid      (sel_valid),
    .sel_beat       (sel_beat),
    .sel_meta       (sel_meta),
    .sel_ready      (sel_ready)
  );

  udp_tx_framer udp_tx_framer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel_valid      (sel_valid),
    .sel_beat       (sel_beat),
    .sel_meta       (sel_meta),
    .sel_ready      (sel_ready),
    .ipv4_tx_valid  (ipv4_tx_valid),
    .ipv4_tx_beat   (ipv4_tx_beat),
    .ipv4_tx_credit (ipv4_tx_credit)
  );

  udp_rx_parser udp_rx_parser_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ipv4_rx_valid (ipv4_rx_valid),
    .ipv4_rx_beat  (ipv4_rx_beat),
    .user_rx_valid (user_rx_valid),
    .user_rx_beat  (user_rx_beat),
    .user_rx_meta  (user_rx_meta),
    .user_rx_err   (user_rx_err)
  );

endmodule : udp_top

// ==== test/udp_top_asserts.sv ====
module udp_top_asserts (
  input logic               clk,
  input logic               rst_n,
  input logic               user_tx_valid,
  input logic               user_tx_credit,
  input logic               ipv4_tx_valid,
  input logic               ipv4_tx_credit,
  input logic               user_rx_valid,
  input udp_pkg::udp_beat_t user_rx_beat,
  input logic               user_rx_err
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0] ipv4_outstanding;
  logic [3:0] user_outstanding;

  // beats sent on each credit link that have not yet been paid back.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ipv4_outstanding <= '0;
      user_outstanding <= '0;
    end else begin
      ipv4_outstanding <= ipv4_outstanding + 4'(ipv4_tx_valid) - 4'(ipv4_tx_credit);
      user_outstanding <= user_outstanding + 4'(user_tx_valid) - 4'(user_tx_credit);
    end
  end

  ipv4_credit_available: assert property (@(posedge clk) disable iff (!rst_n)
    ipv4_tx_valid |-> ipv4_outstanding < 4'(udp_pkg::TX_CREDITS))
    else $error("ipv4_tx_valid was high with no IPv4 credit left");

  user_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    user_outstanding <= 4'(udp_pkg::TX_CREDITS))
    else $error("more user beats outstanding than the credit limit allows");

  rx_err_on_eof: assert property (@(posedge clk) disable iff (!rst_n)
    user_rx_err |-> user_rx_valid && user_rx_beat.eof)
    else $error("user_rx_err was high outside an eof beat");

endmodule : udp_top_asserts

bind udp_top udp_top_asserts udp_top_asserts_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .user_tx_valid  (user_tx_valid),
  .user_tx_credit (user_tx_credit),
  .ipv4_tx_valid  (ipv4_tx_valid),
  .ipv4_tx_credit (ipv4_tx_credit),
  .user_rx_valid  (user_rx_valid),
  .user_rx_beat   (user_rx_beat),
  .user_rx_err    (user_rx_err)
);

// ==== test/udp_top_tb.sv ====
module udp_top_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 2000;

  typedef struct packed {
    udp_pkg::udp_beat_t    beat;
    udp_pkg::udp_rx_meta_t meta;
    logic                  err;
  } rx_expect_t;

  logic                  clk;
  logic                  rst_n;
  logic                  user_tx_valid;
  udp_pkg::udp_beat_t    user_tx_beat;
  udp_pkg::udp_tx_meta_t user_tx_meta;
  logic                  user_tx_credit;
  logic                  ipv4_tx_valid;
  udp_pkg::udp_beat_t    ipv4_tx_beat;
  logic                  ipv4_tx_credit;
  logic                  ipv4_rx_valid;
  udp_pkg::udp_beat_t    ipv4_rx_beat;
  logic                  user_rx_valid;
  udp_pkg::udp_beat_t    user_rx_beat;
  udp_pkg::udp_rx_meta_t user_rx_meta;
  logic                  user_rx_err;

  integer             seed;
  udp_pkg::udp_beat_t tx_exp[$];
  rx_expect_t         rx_exp[$];
  logic [7:0]         user_pay[$];
  int                 user_len[2];
  int                 tx_seen = 0;
  int                 user_returned = 0;
  int                 user_sent;
  int                 ipv4_returned;
  logic               hold_credits;

  udp_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_with_failure();
  endtask

  task automatic expect_tx_header(input logic [15:0] dst, input logic [15:0] len);
    logic [63:0]        hdr;
    udp_pkg::udp_beat_t b;
    hdr = {16'd5000, dst, len + 16'd8, 16'h0000};
    for (int i = 0; i < 8; i++) begin
      b.data = hdr[63-8*i -: 8];
      b.sof  = (i == 0);
      b.eof  = 1'b0;
      tx_exp.push_back(b);
    end
  endtask

  task automatic expect_tx_byte(input logic [7:0] data, input logic last);
    udp_pkg::udp_beat_t b;
    b.data = data;
    b.sof  = 1'b0;
    b.eof  = last;
    tx_exp.push_back(b);
  endtask

  // the announcement comes first, then both user datagrams in order.
  task automatic build_tx_expectations();
    logic [31:0] text;
    text = "UDPU";
    expect_tx_header(16'd5001, 16'd4);
    for (int j = 0; j < 4; j++) begin
      expect_tx_byte(text[31-8*j -: 8], j == 3);
    end
    for (int d = 0; d < 2; d++) begin
      user_len[d] = 1 + ($random(seed) & 15);
      expect_tx_header(16'd6000 + 16'(d), 16'(user_len[d]));
      for (int j = 0; j < user_len[d]; j++) begin
        user_pay.push_back(8'($random(seed)));
        expect_tx_byte(user_pay[user_pay.size()-1], j == user_len[d] - 1);
      end
    end
  endtask

  task automatic drive_user_datagrams();
    int k;
    int timer;
    k = 0;
    for (int d = 0; d < 2; d++) begin
      for (int j = 0; j < user_len[d]; j++) begin
        @(negedge clk);
        user_tx_valid = 1'b0;
        timer = 0;
        while (user_sent - user_returned >= udp_pkg::TX_CREDITS) begin
          timer++;
          if (timer > WAIT_LIMIT) report_timeout("a user transmit credit");
          @(negedge clk);
        end
        user_tx_valid            = 1'b1;
        user_tx_beat.data        = user_pay[k];
        user_tx_beat.sof         = (j == 0);
        user_tx_beat.eof         = (j == user_len[d] - 1);
        user_tx_meta.dst_port    = 16'd6000 + 16'(d);
        user_tx_meta.payload_len = 16'(user_len[d]);
        user_sent++;
        k++;
      end
    end
    @(negedge clk);
    user_tx_valid = 1'b0;
  endtask

  // returns one credit per beat seen, at random spacing, unless held back.
  task automatic return_ipv4_credits();
    forever begin
      @(negedge clk);
      ipv4_tx_credit = 1'b0;
      if (!hold_credits && ipv4_returned < tx_seen) begin
        if (($random(seed) & 3) != 0) begin
          ipv4_tx_credit = 1'b1;
          ipv4_returned++;
        end
      end
    end
  endtask

  task automatic check_credit_pause();
    int timer;
    timer = 0;
    while (tx_seen < udp_pkg::TX_CREDITS) begin
      timer++;
      if (timer > WAIT_LIMIT) report_timeout("the first beats on ipv4_tx");
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    assert (tx_seen == udp_pkg::TX_CREDITS) else begin
      $display("ERROR ipv4_tx_valid beat count got %h expected %h",
               tx_seen, udp_pkg::TX_CREDITS);
      stop_with_failure();
    end
    hold_credits = 1'b0;
  endtask

  task automatic wait_tx_drained();
    int timer;
    timer = 0;
    while (tx_exp.size() != 0 || ipv4_returned != tx_seen) begin
      timer++;
      if (timer > WAIT_LIMIT) report_timeout("the datagrams on ipv4_tx");
      @(negedge clk);
    end
  endtask

  task automatic wait_rx_drained();
    int timer;
    timer = 0;
    while (rx_exp.size() != 0) begin
      timer++;
      if (timer > WAIT_LIMIT) report_timeout("the payload on user_rx");
      @(negedge clk);
    end
  endtask

  task automatic send_rx_datagram(input logic [15:0] src, input logic [15:0] dst,
                                  input int pay_len, input int extra_len);
    logic [63:0] hdr;
    logic [15:0] len_field;
    logic [7:0]  b;
    rx_expect_t  e;
    len_field = 16'(pay_len + extra_len + 8);
    hdr = {src, dst, len_field, 16'h0000};
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      ipv4_rx_valid     = 1'b1;
      ipv4_rx_beat.data = hdr[63-8*i -: 8];
      ipv4_rx_beat.sof  = (i == 0);
      ipv4_rx_beat.eof  = 1'b0;
    end
    for (int j = 0; j < pay_len; j++) begin
      b = 8'($random(seed));
      if (dst == 16'd5000) begin
        e.beat.data        = b;
        e.beat.sof         = (j == 0);
        e.beat.eof         = (j == pay_len - 1);
        e.meta.src_port    = src;
        e.meta.payload_len = len_field - 16'd8;
        e.err              = (j == pay_len - 1) && (pay_len != int'(len_field) - 8);
        rx_exp.push_back(e);
      end
      @(negedge clk);
      ipv4_rx_beat.data = b;
      ipv4_rx_beat.sof  = 1'b0;
      ipv4_rx_beat.eof  = (j == pay_len - 1);
    end
    @(negedge clk);
    ipv4_rx_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst_n && ipv4_tx_valid) begin
      tx_seen = tx_seen + 1;
      assert (tx_exp.size() != 0) else begin
        $display("a beat appeared on ipv4_tx with no datagram pending");
        stop_with_failure();
      end
      assert (ipv4_tx_beat == tx_exp[0]) else begin
        $display("ERROR ipv4_tx_beat got %h expected %h", ipv4_tx_beat, tx_exp[0]);
        stop_with_failure();
      end
      void'(tx_exp.pop_front());
    end
  end

  always @(posedge clk) begin
    if (rst_n && user_tx_credit) begin
      user_returned = user_returned + 1;
    end
  end

  // a dropped datagram must never reach this block.
  always @(posedge clk) begin
    if (rst_n && user_rx_valid) begin
      assert (rx_exp.size() != 0) else begin
        $display("user_rx_valid was high with no payload expected");
        stop_with_failure();
      end
      assert (user_rx_beat == rx_exp[0].beat) else begin
        $display("ERROR user_rx_beat got %h expected %h", user_rx_beat, rx_exp[0].beat);
        stop_with_failure();
      end
      assert (user_rx_meta == rx_exp[0].meta) else begin
        $display("ERROR user_rx_meta got %h expected %h", user_rx_meta, rx_exp[0].meta);
        stop_with_failure();
      end
      assert (user_rx_err == rx_exp[0].err) else begin
        $display("ERROR user_rx_err got %h expected %h", user_rx_err, rx_exp[0].err);
        stop_with_failure();
      end
      void'(rx_exp.pop_front());
    end
  end

  initial begin
    seed           = 32'h1656068d;
    rst_n          = 1'b0;
    user_tx_valid  = 1'b0;
    user_tx_beat   = '0;
    user_tx_meta   = '0;
    ipv4_tx_credit = 1'b0;
    ipv4_rx_valid  = 1'b0;
    ipv4_rx_beat   = '0;
    user_sent      = 0;
    ipv4_returned  = 0;
    hold_credits   = 1'b1;
    build_tx_expectations();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      return_ipv4_credits();
    join_none
    fork
      drive_user_datagrams();
      check_credit_pause();
    join
    wait_tx_drained();
    assert (user_returned == user_sent) else begin
      $display("ERROR user_tx_credit count got %h expected %h", user_returned, user_sent);
      stop_with_failure();
    end
    send_rx_datagram(16'd7000, 16'd5000, 1 + ($random(seed) & 15), 0);
    send_rx_datagram(16'd7001, 16'd5002, 5, 0);
    send_rx_datagram(16'd7002, 16'd5000, 1 + ($random(seed) & 15), 3);
    wait_rx_drained();
    repeat (2) @(negedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule : udp_top_tb

// ==== udp_top.f ====
src/udp_pkg.sv
src/udp_announce.sv
src/udp_tx_select.sv
src/udp_tx_framer.sv
src/udp_rx_parser.sv
src/udp_top.sv
test/udp_top_asserts.sv
test/udp_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := udp_top_tb
FILELIST  := udp_top.f
OBJ_DIR   := obj_dir
SIM_EXE   := sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_EXE)
	./$(OBJ_DIR)/$(SIM_EXE)

clean:
	rm -rf $(OBJ_DIR)
